// ==== all.f ====
verilog/la_pkg.sv
verilog/trigger_unit.sv
verilog/sample_buffer.sv
verilog/credit_counter.sv
verilog/port_arbiter.sv
verilog/tx_framer.sv
verilog/debug_core_top.sv
testbench/debug_core_assertions.sv
testbench/tb_debug_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the debug core testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module tb_debug_core -o tb_debug_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_debug_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== testbench/tb_debug_core.sv ====
`timescale 1ns/1ps

module tb_debug_core;
  import la_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DLY   = 1;
  // about 250 cycles per capture at the slowest credit rate, four captures
  // and trigger waits under 32 cycles come to about 1100, then close to
  // twice that as margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                           txclk = 1'b0;
  logic                           rstn;
  logic                           arm;
  la_cfg_t                        cfg;
  logic [PORT_NUM*PORT_WIDTH-1:0] testport;
  logic                           credit_return = 1'b0;
  logic                           tx_valid;
  tx_word_t                       tx_word;
  logic                           busy;

  logic [31:0] port_count  = '0;
  logic [1:0]  credit_mask = 2'b00;
  logic        busy_q      = 1'b0;
  int          cycle_count = 0;
  int          in_flight   = 0;
  int          word_num    = 0;
  int          rand_val;
  int          seed = 32'h94ca_f3b6;
  string       test_name;
  tx_word_t    expected_q[$];

  always #HALF_PERIOD txclk = ~txclk;

  debug_core_top i_dut (
    .i_txclk         (txclk),
    .i_rstn          (rstn),
    .i_arm           (arm),
    .i_cfg           (cfg),
    .i_testport      (testport),
    .i_credit_return (credit_return),
    .o_tx_valid      (tx_valid),
    .o_tx_word       (tx_word),
    .o_busy          (busy)
  );

  bind debug_core_top debug_core_assertions u_assertions (
    .i_txclk         (i_txclk),
    .i_rstn          (i_rstn),
    .i_tx_valid      (o_tx_valid),
    .i_tx_word       (o_tx_word),
    .i_busy          (o_busy),
    .i_credit_return (i_credit_return)
  );

  // port p counts, with its index in the top byte
  function automatic logic [31:0] port_value(int p, logic [31:0] count);
    return (32'(p) << 24) + count;
  endfunction

  // first count that fires, only port 0 is masked
  // the arm cycle itself counts as a match in edge mode
  function automatic logic [31:0] first_trigger(logic [31:0] arm_cnt, logic [31:0] mask,
                                                logic [31:0] value, logic edge_on);
    logic [31:0] cnt;
    logic        hit;
    logic        prev;
    cnt  = arm_cnt + 32'd1;
    prev = 1'b1;
    for (int i = 0; i < 64; i++) begin
      hit = ((cnt & mask) == (value & mask));
      if (hit && (!edge_on || !prev)) return cnt;
      prev = hit;
      cnt  = cnt + 32'd1;
    end
    return cnt;
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(string field, logic [31:0] exp_val, logic [31:0] act_val);
    abort_run($sformatf("CHECK FAILED %s word %0d %s: expected %h actual %h",
                        test_name, word_num, field, exp_val, act_val));
  endtask

  task automatic expect_word(logic [31:0] data, logic last);
    tx_word_t w;
    w.data = data;
    w.last = last;
    expected_q.push_back(w);
  endtask

  task automatic check_word();
    tx_word_t exp_word;
    if (expected_q.size() == 0) begin
      abort_run($sformatf("%s: word %h arrived after the last expected word",
                          test_name, tx_word.data));
    end else begin
      exp_word = expected_q.pop_front();
      assert (tx_word.data == exp_word.data)
        else report_mismatch("data", exp_word.data, tx_word.data);
      assert (tx_word.last == exp_word.last)
        else report_mismatch("last", 32'(exp_word.last), 32'(tx_word.last));
      word_num++;
    end
  endtask

  // **************************************************
  // one capture: arm, build the expected stream, drain
  // **************************************************
  task automatic run_capture(string name, logic [31:0] mask, logic [31:0] value,
                             logic edge_on, logic [PORT_NUM-1:0] en, logic [1:0] cr_mask);
    logic [31:0] first;
    test_name   = name;
    word_num    = 0;
    credit_mask = cr_mask;
    @(posedge txclk);
    #DRIVE_DLY;
    cfg.trig_mask  = {{(PORT_NUM-1)*PORT_WIDTH{1'b0}}, mask};
    cfg.trig_value = {{(PORT_NUM-1)*PORT_WIDTH{1'b0}}, value};
    cfg.edge_mode  = edge_on;
    cfg.port_en    = en;
    arm            = 1'b1;
    @(negedge txclk);
    first = first_trigger(port_count, mask, value, edge_on);
    expect_word(HDR_STATUS, 1'b0);
    expect_word(STATUS_DONE, 1'b1);
    for (int p = 0; p < PORT_NUM; p++) begin
      if (en[p]) begin
        expect_word(HDR_PORT | 32'(p), 1'b0);
        for (int i = 0; i < SAMPLE_DEPTH; i++) begin
          expect_word(port_value(p, first + 32'(i)), i == SAMPLE_DEPTH - 1);
        end
      end
    end
    @(posedge txclk);
    #DRIVE_DLY;
    arm = 1'b0;
    while (expected_q.size() != 0 || busy) @(negedge txclk);
    $display("%s: %0d words checked", name, word_num);
  endtask

  always_comb begin
    for (int p = 0; p < PORT_NUM; p++) begin
      testport[p*PORT_WIDTH +: PORT_WIDTH] = port_value(p, port_count);
    end
  end

  // free-running ports and random credit return
  always @(posedge txclk) begin
    #DRIVE_DLY;
    port_count    = port_count + 32'd1;
    rand_val      = $random(seed);
    credit_return = (in_flight > 0) && ((rand_val[1:0] & credit_mask) == 2'b00);
  end

  always @(posedge txclk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run("timeout, the frames did not finish within the cycle limit");
    end
  end

  // stream sampled mid-cycle
  always @(negedge txclk) begin
    if (rstn) begin
      if (tx_valid) check_word();
      in_flight = in_flight + int'(tx_valid) - int'(credit_return);
      assert (in_flight <= CREDIT_MAX) else abort_run("more words in flight than link credits");
      assert (busy || !tx_valid) else abort_run("word sent while the core was idle");
      assert (busy || !busy_q || expected_q.size() == 0)
        else abort_run("busy fell before the last frame word");
      busy_q = busy;
    end
  end

  initial begin
    rstn = 1'b0;
    arm  = 1'b0;
    cfg  = '0;
    repeat (3) @(posedge txclk);
    #DRIVE_DLY;
    rstn = 1'b1;
    repeat (2) @(posedge txclk);
    // level trigger, slow credit return
    run_capture("all_ports", 32'h0000_001F, 32'h0000_0005, 1'b0, 3'b111, 2'b11);
    run_capture("port1_off", 32'h0000_000F, 32'h0000_000C, 1'b0, 3'b101, 2'b01);
    // arm inside a run of matches, capture waits for the next rising match
    while (port_count[3:0] != 4'd9) @(negedge txclk);
    run_capture("edge_mode", 32'h0000_0008, 32'h0000_0008, 1'b1, 3'b111, 2'b01);
    run_capture("full_rate", 32'h0000_0003, 32'h0000_0002, 1'b0, 3'b111, 2'b00);
    $display("Test OK");
    $finish;
  end

endmodule

// ==== testbench/debug_core_assertions.sv ====
`timescale 1ns/1ps

module debug_core_assertions (
  input logic             i_txclk,
  input logic             i_rstn,
  input logic             i_tx_valid,
  input la_pkg::tx_word_t i_tx_word,
  input logic             i_busy,
  input logic             i_credit_return
);
  import la_pkg::*;

  logic [CREDIT_W:0] in_flight;
  logic [ADDR_W:0]   word_idx;
  logic              stat_frame;
  logic              exp_last;

  // words on the link not yet credited by the receiver
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      in_flight <= '0;
    end else if (i_tx_valid && !i_credit_return) begin
      in_flight <= in_flight + 1'b1;
    end else if (!i_tx_valid && i_credit_return) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  // position inside the current frame
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      word_idx   <= '0;
      stat_frame <= 1'b0;
    end else if (i_tx_valid) begin
      word_idx <= i_tx_word.last ? '0 : word_idx + 1'b1;
      if (word_idx == '0) begin
        stat_frame <= (i_tx_word.data == HDR_STATUS);
      end
    end
  end

  // status frame ends on word 1, a port frame after header and samples
  assign exp_last = stat_frame ? (word_idx == (ADDR_W+1)'(1))
                               : (word_idx == (ADDR_W+1)'(SAMPLE_DEPTH));

  // **************************************************
  // stream protocol
  // **************************************************
  a_credit_bound: assert property (@(posedge i_txclk) disable iff (!i_rstn)
    in_flight <= (CREDIT_W+1)'(CREDIT_MAX))
    else $error("more link words in flight than credits");

  // a word needs a free slot at the receiver before it goes out
  a_send_credit: assert property (@(posedge i_txclk) disable iff (!i_rstn)
    i_tx_valid |-> in_flight < (CREDIT_W+1)'(CREDIT_MAX))
    else $error("word sent with no credit left");

  a_last_place: assert property (@(posedge i_txclk) disable iff (!i_rstn)
    i_tx_valid |-> (i_tx_word.last == exp_last))
    else $error("last bit on the wrong word of a frame");

  a_idle_quiet: assert property (@(posedge i_txclk) disable iff (!i_rstn)
    !i_busy |-> !i_tx_valid)
    else $error("word sent while not busy");

  a_busy_fall: assert property (@(posedge i_txclk) disable iff (!i_rstn)
    $fell(i_busy) |-> $past(i_tx_valid && i_tx_word.last))
    else $error("busy fell without a final frame word");

endmodule

// ==== verilog/debug_core_top.sv ====
`timescale 1ns/1ps

module debug_core_top (
  input  logic                                           i_txclk,
  input  logic                                           i_rstn,
  input  logic                                           i_arm,
  input  la_pkg::la_cfg_t                                i_cfg,
  input  logic [la_pkg::PORT_NUM*la_pkg::PORT_WIDTH-1:0] i_testport,
  input  logic                                           i_credit_return,
  output logic                                           o_tx_valid,
  output la_pkg::tx_word_t                               o_tx_word,
  output logic                                           o_busy
);
  import la_pkg::*;

  logic                           trig_fire;
  logic [PORT_NUM-1:0]            captured;
  logic [PORT_NUM-1:0]            rd_en;
  logic [ADDR_W-1:0]              rd_addr;
  logic [PORT_NUM*PORT_WIDTH-1:0] rd_data;
  logic                           sel_valid;
  logic [PORT_IDX_W-1:0]          sel_port;
  logic                           port_done;
  logic                           send;
  logic                           credit_ok;

  trigger_unit u_trigger (
    .i_txclk     (i_txclk),
    .i_rstn      (i_rstn),
    .i_arm       (i_arm),
    .i_cfg       (i_cfg),
    .i_testport  (i_testport),
    .o_trig_fire (trig_fire)
  );

  // **************************************************
  // one capture buffer per test port
  // **************************************************
  for (genvar p = 0; p < PORT_NUM; p++) begin : g_buf
    sample_buffer u_buf (
      .i_txclk     (i_txclk),
      .i_rstn      (i_rstn),
      .i_arm       (i_arm),
      .i_trig_fire (trig_fire),
      .i_sample    (i_testport[p*PORT_WIDTH +: PORT_WIDTH]),
      .i_rd_en     (rd_en[p]),
      .i_rd_addr   (rd_addr),
      .o_rd_data   (rd_data[p*PORT_WIDTH +: PORT_WIDTH]),
      .o_captured  (captured[p])
    );
  end

  credit_counter u_credit (
    .i_txclk         (i_txclk),
    .i_rstn          (i_rstn),
    .i_send          (send),
    .i_credit_return (i_credit_return),
    .o_credit_ok     (credit_ok)
  );

  port_arbiter u_arb (
    .i_txclk     (i_txclk),
    .i_rstn      (i_rstn),
    .i_arm       (i_arm),
    .i_port_en   (i_cfg.port_en),
    .i_captured  (captured),
    .i_port_done (port_done),
    .o_sel_valid (sel_valid),
    .o_sel_port  (sel_port)
  );

  tx_framer u_framer (
    .i_txclk        (i_txclk),
    .i_rstn         (i_rstn),
    .i_arm          (i_arm),
    .i_all_captured (&captured),
    .i_sel_valid    (sel_valid),
    .i_sel_port     (sel_port),
    .i_credit_ok    (credit_ok),
    .i_rd_data      (rd_data),
    .o_rd_en        (rd_en),
    .o_rd_addr      (rd_addr),
    .o_port_done    (port_done),
    .o_send         (send),
    .o_tx_valid     (o_tx_valid),
    .o_tx_word      (o_tx_word),
    .o_busy         (o_busy)
  );

endmodule

// ==== verilog/tx_framer.sv ====
`timescale 1ns/1ps

module tx_framer (
  input  logic                                           i_txclk,
  input  logic                                           i_rstn,
  input  logic                                           i_arm,
  input  logic                                           i_all_captured,
  input  logic                                           i_sel_valid,
  input  logic [la_pkg::PORT_IDX_W-1:0]                  i_sel_port,
  input  logic                                           i_credit_ok,
  input  logic [la_pkg::PORT_NUM*la_pkg::PORT_WIDTH-1:0] i_rd_data,
  output logic [la_pkg::PORT_NUM-1:0]                    o_rd_en,
  output logic [la_pkg::ADDR_W-1:0]                      o_rd_addr,
  output logic                                           o_port_done,
  output logic                                           o_send,
  output logic                                           o_tx_valid,
  output la_pkg::tx_word_t                               o_tx_word,
  output logic                                           o_busy
);
  import la_pkg::*;

  fr_state_t             state;
  logic                  stat_sent;
  logic [PORT_IDX_W-1:0] cur_port;
  logic                  data_end;
  logic                  valid_q;
  logic                  last_q;
  logic                  from_mem_q;
  logic [31:0]           word_q;
  logic [31:0]           next_word;

  // **************************************************
  // word commit, one credit per word
  // **************************************************
  always_comb begin
    o_send = 1'b0;
    if (i_credit_ok && !i_arm) begin
      case (state)
        IDLE:      o_send = i_all_captured && !stat_sent;
        STAT_END:  o_send = 1'b1;
        PORT_HDR:  o_send = i_sel_valid;
        PORT_DATA: o_send = 1'b1;
        default:   o_send = 1'b0;
      endcase
    end
  end

  assign data_end    = (state == PORT_DATA) && (o_rd_addr == ADDR_W'(SAMPLE_DEPTH - 1));
  assign o_port_done = o_send && data_end;

  // read goes out with its credit, only the current port
  assign o_rd_en = (o_send && state == PORT_DATA) ? (PORT_NUM'(1) << cur_port) : '0;

  always_comb begin
    case (state)
      IDLE:     next_word = HDR_STATUS;
      STAT_END: next_word = STATUS_DONE;
      default:  next_word = HDR_PORT | {24'd0, 8'(i_sel_port)};
    endcase
  end

  // **************************************************
  // state machine
  // **************************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      state     <= IDLE;
      stat_sent <= 1'b0;
      cur_port  <= '0;
      o_rd_addr <= '0;
      o_busy    <= 1'b0;
    end else if (i_arm) begin
      state     <= IDLE;
      stat_sent <= 1'b0;
      o_rd_addr <= '0;
      o_busy    <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (o_send) begin
            stat_sent <= 1'b1;
            state     <= STAT_END;
          end
        end
        STAT_END: begin
          if (o_send) state <= PORT_HDR;
        end
        PORT_HDR: begin
          if (!i_sel_valid) begin
            // nothing left to send
            state  <= IDLE;
            o_busy <= 1'b0;
          end else if (o_send) begin
            cur_port  <= i_sel_port;
            o_rd_addr <= '0;
            state     <= PORT_DATA;
          end
        end
        PORT_DATA: begin
          if (o_send) begin
            o_rd_addr <= o_rd_addr + 1'b1;
            if (data_end) state <= PORT_HDR;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // **************************************************
  // output stage, one cycle behind the commit
  // **************************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      from_mem_q <= 1'b0;
    end else begin
      valid_q <= o_send;
      if (o_send) begin
        last_q     <= (state == STAT_END) || data_end;
        from_mem_q <= (state == PORT_DATA);
      end
    end
  end

  always_ff @(posedge i_txclk) begin
    if (o_send) begin
      word_q <= next_word;
    end
  end

  // cur_port only moves on the next header commit, after this word
  assign o_tx_valid     = valid_q;
  assign o_tx_word.last = last_q;
  assign o_tx_word.data = from_mem_q ? i_rd_data[cur_port*PORT_WIDTH +: PORT_WIDTH] : word_q;

endmodule

// ==== verilog/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter (
  input  logic                          i_txclk,
  input  logic                          i_rstn,
  input  logic                          i_arm,
  input  logic [la_pkg::PORT_NUM-1:0]   i_port_en,
  input  logic [la_pkg::PORT_NUM-1:0]   i_captured,
  input  logic                          i_port_done,
  output logic                          o_sel_valid,
  output logic [la_pkg::PORT_IDX_W-1:0] o_sel_port
);
  import la_pkg::*;

  logic [PORT_NUM-1:0] en_q;
  logic [PORT_NUM-1:0] sent;
  logic [PORT_NUM-1:0] ready;

  // enable and sent mask, both start over on arm
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      en_q <= '0;
      sent <= '0;
    end else if (i_arm) begin
      en_q <= i_port_en;
      sent <= '0;
    end else if (i_port_done) begin
      sent[o_sel_port] <= 1'b1;
    end
  end

  assign ready = en_q & i_captured & ~sent;

  // lowest ready index wins
  always_comb begin
    o_sel_valid = 1'b0;
    o_sel_port  = '0;
    for (int p = PORT_NUM - 1; p >= 0; p--) begin
      if (ready[p]) begin
        o_sel_valid = 1'b1;
        o_sel_port  = PORT_IDX_W'(p);
      end
    end
  end

endmodule

// ==== verilog/credit_counter.sv ====
`timescale 1ns/1ps

module credit_counter (
  input  logic i_txclk,
  input  logic i_rstn,
  input  logic i_send,
  input  logic i_credit_return,
  output logic o_credit_ok
);
  import la_pkg::*;

  logic [CREDIT_W-1:0] count;

  // receiver starts with all slots free
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      count <= CREDIT_W'(CREDIT_MAX);
    end else begin
      case ({i_send, i_credit_return})
        2'b10: begin
          if (count != '0) begin
            count <= count - 1'b1;
          end
        end
        2'b01: begin
          if (count != CREDIT_W'(CREDIT_MAX)) begin
            count <= count + 1'b1;
          end
        end
        // both or neither, count unchanged
        default: count <= count;
      endcase
    end
  end

  assign o_credit_ok = (count != '0);

endmodule

// ==== verilog/sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer (
  input  logic                         i_txclk,
  input  logic                         i_rstn,
  input  logic                         i_arm,
  input  logic                         i_trig_fire,
  input  logic [la_pkg::PORT_WIDTH-1:0] i_sample,
  input  logic                         i_rd_en,
  input  logic [la_pkg::ADDR_W-1:0]     i_rd_addr,
  output logic [la_pkg::PORT_WIDTH-1:0] o_rd_data,
  output logic                         o_captured
);
  import la_pkg::*;

  logic [PORT_WIDTH-1:0] mem [SAMPLE_DEPTH];
  logic [PORT_WIDTH-1:0] sample_q;
  logic [ADDR_W-1:0]     wr_addr;
  logic                  capturing;
  logic                  wr_en;
  logic [ADDR_W-1:0]     wr_ptr;

  // input register, lines the sample up with the fire pulse
  // so the matching value lands at address 0
  always_ff @(posedge i_txclk) begin
    sample_q <= i_sample;
  end

  assign wr_en  = i_trig_fire || capturing;
  assign wr_ptr = i_trig_fire ? '0 : wr_addr;

  // **************************************************
  // capture control
  // **************************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      wr_addr    <= '0;
      capturing  <= 1'b0;
      o_captured <= 1'b0;
    end else if (i_arm) begin
      wr_addr    <= '0;
      capturing  <= 1'b0;
      o_captured <= 1'b0;
    end else if (i_trig_fire) begin
      wr_addr   <= ADDR_W'(1);
      capturing <= 1'b1;
    end else if (capturing) begin
      wr_addr <= wr_addr + 1'b1;
      // last slot written this cycle
      if (wr_addr == ADDR_W'(SAMPLE_DEPTH - 1)) begin
        capturing  <= 1'b0;
        o_captured <= 1'b1;
      end
    end
  end

  // **************************************************
  // memory
  // **************************************************
  always_ff @(posedge i_txclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= sample_q;
    end
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge i_txclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

// ==== verilog/trigger_unit.sv ====
`timescale 1ns/1ps

module trigger_unit (
  input  logic                                         i_txclk,
  input  logic                                         i_rstn,
  input  logic                                         i_arm,
  input  la_pkg::la_cfg_t                              i_cfg,
  input  logic [la_pkg::PORT_NUM*la_pkg::PORT_WIDTH-1:0] i_testport,
  output logic                                         o_trig_fire
);
  import la_pkg::*;

  logic [PORT_NUM*PORT_WIDTH-1:0] mask_q;
  logic [PORT_NUM*PORT_WIDTH-1:0] value_q;
  logic                           edge_q;
  logic                           armed;
  logic                           prev_match;
  logic                           match;
  logic                           hit;

  // pattern latched on arm
  always_ff @(posedge i_txclk) begin
    if (i_arm) begin
      mask_q  <= i_cfg.trig_mask;
      value_q <= i_cfg.trig_value;
      edge_q  <= i_cfg.edge_mode;
    end
  end

  // all masked bits of all ports equal to the value
  assign match = ((i_testport & mask_q) == (value_q & mask_q));

  // edge mode wants a match right after a miss
  assign hit = armed && match && (!edge_q || !prev_match);

  // **************************************************
  // armed flag and fire pulse
  // **************************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      armed       <= 1'b0;
      prev_match  <= 1'b0;
      o_trig_fire <= 1'b0;
    end else if (i_arm) begin
      armed       <= 1'b1;
      // a match already present on the first armed cycle is no edge
      prev_match  <= 1'b1;
      o_trig_fire <= 1'b0;
    end else begin
      prev_match  <= match;
      o_trig_fire <= hit;
      if (hit) begin
        // one shot per arm
        armed <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/la_pkg.sv ====
package la_pkg;

  // **************************************************
  // sizes
  // **************************************************
  localparam int PORT_NUM     = 3;
  localparam int PORT_WIDTH   = 32;
  localparam int SAMPLE_DEPTH = 16;
  localparam int ADDR_W       = 4;
  localparam int PORT_IDX_W   = 2;

  // link receiver holds this many word slots after reset
  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W   = 3;

  // **************************************************
  // frame words
  // **************************************************
  // 00_xxxxxx marks status, FF_xxxxxx marks port data
  localparam logic [31:0] HDR_STATUS  = 32'h00_000000;
  localparam logic [31:0] STATUS_DONE = 32'hFFFFFFFF;
  // low byte carries the port index
  localparam logic [31:0] HDR_PORT    = 32'hFF_000000;

  // **************************************************
  // types
  // **************************************************
  // analyzer setup, taken while arm is high
  typedef struct packed {
    logic [PORT_NUM*PORT_WIDTH-1:0] trig_mask;
    logic [PORT_NUM*PORT_WIDTH-1:0] trig_value;
    logic                           edge_mode;
    logic [PORT_NUM-1:0]            port_en;
  } la_cfg_t;

  // one link word, valid travels beside it
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } tx_word_t;

  typedef enum logic [1:0] {
    IDLE,
    STAT_END,
    PORT_HDR,
    PORT_DATA
  } fr_state_t;

endpackage
